/* build.f */
hdl/dsm_pkg.sv
hdl/dsm_cfg_if.sv
hdl/dsm_conf_receiver.sv
hdl/dsm_queue_counters.sv
hdl/dsm_done_detect.sv
hdl/dsm_writer.sv
hdl/dsm_top.sv
testbench/dsm_tb.sv

/* hdl/dsm_cfg_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dsm_cfg_if ();
  import dsm_pkg::*;

  logic                  cfg_ready;  // sticky after first accepted word
  logic [addr_width-1:0] addr_base;
  logic [qtd_width-1:0]  line_quota; // region size in lines
  logic                  cfg_load;

  modport source (
    output cfg_ready, addr_base, line_quota, cfg_load
  );

  modport sink (
    input cfg_ready, addr_base, line_quota, cfg_load
  );

endinterface

`default_nettype wire

/* hdl/dsm_conf_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module dsm_conf_receiver #(
  parameter int acc_id = 5
) (
  input  wire logic                         clk,
  input  wire logic                         dsm_rst_internal,
  input  wire logic [1:0]                   conf_valid,
  input  wire logic [dsm_pkg::conf_width-1:0] conf,
  dsm_cfg_if.source                         cfg
);
  import dsm_pkg::*;

  conf_type_e conf_type;
  logic       accept;

  assign conf_type = conf_type_e'(conf_valid);
  assign accept    = (conf_type == conf_out_dsm) &&
                     (conf[id_width-1:0] == id_width'(acc_id));

  always_ff @(posedge clk) begin
    if (dsm_rst_internal) begin
      cfg.cfg_ready <= 1'b0;
      cfg.cfg_load  <= 1'b0;
    end else begin
      cfg.cfg_load <= accept;
      if (accept) begin
        cfg.cfg_ready <= 1'b1;
      end
    end
  end

  // fields held until the next matching word
  always_ff @(posedge clk) begin
    if (accept) begin
      cfg.line_quota <= conf[id_width +: qtd_width];
      cfg.addr_base  <= conf[id_width + qtd_width +: addr_width];
    end
  end

endmodule

`default_nettype wire

/* hdl/dsm_done_detect.sv */
`timescale 1ns/1ps
`default_nettype none

module dsm_done_detect #(
  parameter int num_in_queues  = 20,
  parameter int num_out_queues = 3
) (
  input  wire logic                          clk,
  input  wire logic                          dsm_rst_internal,
  input  wire logic [num_in_queues-1:0]      done_rd,
  input  wire logic [num_out_queues-1:0]     done_wr,
  input  wire logic                          done_acc,
  input  wire logic                          snap,
  output logic                               update_req,
  output logic [dsm_pkg::line_width-1:0]     done_snap
);
  import dsm_pkg::*;

  localparam int pad_bits = line_width - num_in_queues - num_out_queues - 1;

  logic [line_width-1:0] done_vec;
  logic [line_width-1:0] done_q;
  logic [line_width-1:0] done_last;

  assign done_vec = {done_acc, {pad_bits{1'b0}}, done_wr, done_rd};

  always_ff @(posedge clk) begin
    if (dsm_rst_internal) begin
      done_q    <= '0;
      done_last <= '0;
    end else begin
      done_q <= done_vec;
      if (snap) begin
        done_last <= done_q; // flags now reported
      end
    end
  end

  // only flags that went up since the last report
  assign update_req = |(done_q & ~done_last);
  assign done_snap  = done_last;

endmodule

`default_nettype wire

/* hdl/dsm_pkg.sv */
`default_nettype none

package dsm_pkg;

  parameter int addr_width      = 48;
  parameter int qtd_width       = 32;
  parameter int id_width        = 32;
  parameter int tag_width       = 16;
  parameter int line_width      = 512;
  parameter int counts_per_line = 16;

  // address on top, then size, id in the low bits
  parameter int conf_width = addr_width + qtd_width + id_width;

  typedef enum logic [1:0] {
    conf_none      = 2'd0,
    conf_in_queue  = 2'd1,
    conf_out_queue = 2'd2,
    conf_out_dsm   = 2'd3
  } conf_type_e;

  typedef enum logic [2:0] {
    st_idle,
    st_settle,
    st_counts,   // counter lines
    st_status,   // done flag lines up to the aligned count
    st_wait_resp
  } wr_state_e;

endpackage

`default_nettype wire

/* hdl/dsm_queue_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module dsm_queue_counters #(
  parameter int num_in_queues  = 20,
  parameter int num_out_queues = 3
) (
  input  wire logic                      clk,
  input  wire logic                      dsm_rst_internal,
  input  wire logic [num_in_queues-1:0]  acc_req_rd_data_en,
  input  wire logic [num_out_queues-1:0] acc_req_wr_data_en,
  input  wire logic                      snap,
  output logic [((num_in_queues + dsm_pkg::counts_per_line - 1) / dsm_pkg::counts_per_line +
                 (num_out_queues + dsm_pkg::counts_per_line - 1) / dsm_pkg::counts_per_line) *
                dsm_pkg::line_width - 1:0] lines
);
  import dsm_pkg::*;

  localparam int rd_lines = (num_in_queues + counts_per_line - 1) / counts_per_line;
  localparam int wr_lines = (num_out_queues + counts_per_line - 1) / counts_per_line;
  localparam int rd_slots = rd_lines * counts_per_line;
  localparam int wr_slots = wr_lines * counts_per_line;

  logic [qtd_width-1:0]          rd_cnt [num_in_queues];
  logic [qtd_width-1:0]          wr_cnt [num_out_queues];
  logic [rd_slots*qtd_width-1:0] rd_flat;
  logic [wr_slots*qtd_width-1:0] wr_flat;

  always_ff @(posedge clk) begin
    if (dsm_rst_internal) begin
      rd_cnt <= '{default: '0};
      wr_cnt <= '{default: '0};
    end else begin
      for (int i = 0; i < num_in_queues; i++) begin
        rd_cnt[i] <= rd_cnt[i] + qtd_width'(acc_req_rd_data_en[i]); // wraps
      end
      for (int i = 0; i < num_out_queues; i++) begin
        wr_cnt[i] <= wr_cnt[i] + qtd_width'(acc_req_wr_data_en[i]);
      end
    end
  end

  for (genvar i = 0; i < rd_slots; i++) begin : g_rd_slot
    if (i < num_in_queues) begin : g_used
      assign rd_flat[i*qtd_width +: qtd_width] = rd_cnt[i];
    end else begin : g_pad
      assign rd_flat[i*qtd_width +: qtd_width] = '0;
    end
  end

  for (genvar i = 0; i < wr_slots; i++) begin : g_wr_slot
    if (i < num_out_queues) begin : g_used
      assign wr_flat[i*qtd_width +: qtd_width] = wr_cnt[i];
    end else begin : g_pad
      assign wr_flat[i*qtd_width +: qtd_width] = '0;
    end
  end

  // write-queue lines sit above the read lines
  always_ff @(posedge clk) begin
    if (snap) begin
      lines <= {wr_flat, rd_flat};
    end
  end

endmodule

`default_nettype wire

/* hdl/dsm_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dsm_top #(
  parameter int num_in_queues  = 20,
  parameter int num_out_queues = 3,
  parameter int acc_id         = 5
) (
  input  wire logic                             clk,
  input  wire logic                             dsm_rst_internal,
  input  wire logic [1:0]                       conf_valid,
  input  wire logic [dsm_pkg::conf_width-1:0]   conf,
  input  wire logic [num_in_queues-1:0]         done_rd,
  input  wire logic [num_out_queues-1:0]        done_wr,
  input  wire logic                             done_acc,
  input  wire logic [num_in_queues-1:0]         acc_req_rd_data_en,
  input  wire logic [num_out_queues-1:0]        acc_req_wr_data_en,
  input  wire logic                             available_write,
  output logic                                  request_write,
  output logic [dsm_pkg::line_width + dsm_pkg::addr_width + dsm_pkg::tag_width - 1:0] write_data,
  input  wire logic                             write_data_valid,
  input  wire logic [dsm_pkg::tag_width-1:0]    write_queue_id
);
  import dsm_pkg::*;

  localparam int rd_lines = (num_in_queues + counts_per_line - 1) / counts_per_line;
  localparam int wr_lines = (num_out_queues + counts_per_line - 1) / counts_per_line;

  logic [(rd_lines + wr_lines)*line_width-1:0] lines;
  logic [line_width-1:0]                       done_snap;
  logic                                        update_req;
  logic                                        snap;

  dsm_cfg_if i_cfg_if ();

  dsm_conf_receiver #(
    .acc_id(acc_id)
  ) i_conf_receiver (
    .clk              (clk),
    .dsm_rst_internal (dsm_rst_internal),
    .conf_valid       (conf_valid),
    .conf             (conf),
    .cfg              (i_cfg_if.source)
  );

  dsm_queue_counters #(
    .num_in_queues  (num_in_queues),
    .num_out_queues (num_out_queues)
  ) i_queue_counters (
    .clk                (clk),
    .dsm_rst_internal   (dsm_rst_internal),
    .acc_req_rd_data_en (acc_req_rd_data_en),
    .acc_req_wr_data_en (acc_req_wr_data_en),
    .snap               (snap),
    .lines              (lines)
  );

  dsm_done_detect #(
    .num_in_queues  (num_in_queues),
    .num_out_queues (num_out_queues)
  ) i_done_detect (
    .clk              (clk),
    .dsm_rst_internal (dsm_rst_internal),
    .done_rd          (done_rd),
    .done_wr          (done_wr),
    .done_acc         (done_acc),
    .snap             (snap),
    .update_req       (update_req),
    .done_snap        (done_snap)
  );

  dsm_writer #(
    .num_in_queues  (num_in_queues),
    .num_out_queues (num_out_queues),
    .acc_id         (acc_id),
    .settle_cycles  (8)
  ) i_writer (
    .clk              (clk),
    .dsm_rst_internal (dsm_rst_internal),
    .cfg              (i_cfg_if.sink),
    .update_req       (update_req),
    .lines            (lines),
    .done_snap        (done_snap),
    .snap             (snap),
    .available_write  (available_write),
    .write_data_valid (write_data_valid),
    .write_queue_id   (write_queue_id),
    .request_write    (request_write),
    .write_data       (write_data)
  );

endmodule

`default_nettype wire

/* hdl/dsm_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module dsm_writer #(
  parameter int num_in_queues  = 20,
  parameter int num_out_queues = 3,
  parameter int acc_id         = 5,
  parameter int settle_cycles  = 8
) (
  input  wire logic                              clk,
  input  wire logic                              dsm_rst_internal,
  dsm_cfg_if.sink                                cfg,
  input  wire logic                              update_req,
  input  wire logic [((num_in_queues + dsm_pkg::counts_per_line - 1) / dsm_pkg::counts_per_line +
                      (num_out_queues + dsm_pkg::counts_per_line - 1) / dsm_pkg::counts_per_line) *
                     dsm_pkg::line_width - 1:0] lines,
  input  wire logic [dsm_pkg::line_width-1:0]    done_snap,
  output logic                                   snap,
  input  wire logic                              available_write,
  input  wire logic                              write_data_valid,
  input  wire logic [dsm_pkg::tag_width-1:0]     write_queue_id,
  output logic                                   request_write,
  output logic [dsm_pkg::line_width + dsm_pkg::addr_width + dsm_pkg::tag_width - 1:0] write_data
);
  import dsm_pkg::*;

  localparam int rd_lines    = (num_in_queues + counts_per_line - 1) / counts_per_line;
  localparam int wr_lines    = (num_out_queues + counts_per_line - 1) / counts_per_line;
  localparam int count_lines = rd_lines + wr_lines;
  localparam int total_lines = ((count_lines + 1 + 3) / 4) * 4; // at least one status line
  localparam int idx_w       = $clog2(total_lines + 1);
  localparam int settle_w    = $clog2(settle_cycles + 1);

  localparam logic [tag_width-1:0] wr_tag = {1'b1, (tag_width-1)'(acc_id)};

  wr_state_e              state;
  logic [settle_w-1:0]    settle_cnt;
  logic [idx_w-1:0]       line_idx;
  logic [idx_w-1:0]       ack_cnt;
  logic [qtd_width-1:0]   addr_off;
  logic [line_width-1:0]  cur_line;
  logic [addr_width-1:0]  cur_addr;
  logic                   issue;
  logic                   ack_hit;

  assign snap     = (state == st_settle) && (settle_cnt == settle_w'(settle_cycles - 1));
  assign issue    = available_write && ((state == st_counts) || (state == st_status));
  assign ack_hit  = write_data_valid && (write_queue_id == wr_tag);
  assign cur_line = (state == st_counts) ? lines[line_idx*line_width +: line_width] : done_snap;
  assign cur_addr = cfg.addr_base + addr_width'(addr_off);

  always_ff @(posedge clk) begin
    if (dsm_rst_internal) begin
      state         <= st_idle;
      settle_cnt    <= '0;
      line_idx      <= '0;
      ack_cnt       <= '0;
      addr_off      <= '0;
      request_write <= 1'b0;
    end else begin
      request_write <= issue;
      if (ack_hit) begin
        ack_cnt <= ack_cnt + 1'b1;
      end
      if (issue) begin
        line_idx <= line_idx + 1'b1;
        // stay inside the configured region
        if (cfg.line_quota != '0 && addr_off == cfg.line_quota - 1'b1) begin
          addr_off <= '0;
        end else begin
          addr_off <= addr_off + 1'b1;
        end
      end
      case (state)
        st_idle: begin
          if (update_req && cfg.cfg_ready) begin
            settle_cnt <= '0;
            state      <= st_settle;
          end
        end
        st_settle: begin
          settle_cnt <= settle_cnt + 1'b1;
          if (snap) begin
            line_idx <= '0;
            ack_cnt  <= '0; // new update, fresh ack count
            addr_off <= '0;
            state    <= st_counts;
          end
        end
        st_counts: begin
          if (issue && line_idx == idx_w'(count_lines - 1)) begin
            state <= st_status;
          end
        end
        st_status: begin
          if (issue && line_idx == idx_w'(total_lines - 1)) begin
            state <= st_wait_resp;
          end
        end
        st_wait_resp: begin
          if (ack_cnt == idx_w'(total_lines)) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
      if (cfg.cfg_load) begin
        addr_off <= '0; // new base, restart at its first line
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      write_data <= {cur_line, cur_addr, wr_tag};
    end
  end

endmodule

`default_nettype wire

/* testbench/dsm_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dsm_tb;
  import dsm_pkg::*;

  localparam int n_rd        = 20;
  localparam int n_wr        = 3;
  localparam int acc_id      = 5;
  localparam int rd_lines    = (n_rd + counts_per_line - 1) / counts_per_line;
  localparam int wr_lines    = (n_wr + counts_per_line - 1) / counts_per_line;
  localparam int total_lines = ((rd_lines + wr_lines + 1 + 3) / 4) * 4;
  localparam int max_cycles  = 4000;
  localparam logic [tag_width-1:0]  tag  = 16'h8000 | 16'(acc_id); // top bit set, id below
  localparam logic [addr_width-1:0] base = 48'h0000_1234_5600;

  logic                  clk = 1'b0;
  logic                  dsm_rst_internal = 1'b1;
  logic [1:0]            conf_valid = 2'd0;
  logic [conf_width-1:0] conf = '0;
  logic [n_rd-1:0]       done_rd = '0;
  logic [n_wr-1:0]       done_wr = '0;
  logic                  done_acc = 1'b0;
  logic [n_rd-1:0]       acc_req_rd_data_en = '0;
  logic [n_wr-1:0]       acc_req_wr_data_en = '0;
  logic                  available_write = 1'b0;
  logic                  write_data_valid = 1'b0;
  logic [tag_width-1:0]  write_queue_id = '0;
  logic                  request_write;
  logic [line_width+addr_width+tag_width-1:0] write_data;

  int              cyc = 0;
  int              low_left = 0;
  logic            avail_at_edge = 1'b0; // what the DUT sampled at the last edge
  logic [31:0]     rng_stim = 32'h5681;
  logic [31:0]     rng_port = 32'h5681;
  logic [31:0]     cnt_rd [n_rd];
  logic [31:0]     cnt_wr [n_wr];
  logic [line_width-1:0] exp_line [total_lines];
  int              write_idx = 0;
  logic            expect_writes = 1'b0;
  logic            acks_on = 1'b1;
  int              withheld = 0;
  int              acks_sent = 0;
  int              acks_target = 0;
  int              ack_due [$];

  always #50 clk = ~clk;

  dsm_top i_dsm_top (
    .clk                (clk),
    .dsm_rst_internal   (dsm_rst_internal),
    .conf_valid         (conf_valid),
    .conf               (conf),
    .done_rd            (done_rd),
    .done_wr            (done_wr),
    .done_acc           (done_acc),
    .acc_req_rd_data_en (acc_req_rd_data_en),
    .acc_req_wr_data_en (acc_req_wr_data_en),
    .available_write    (available_write),
    .request_write      (request_write),
    .write_data         (write_data),
    .write_data_valid   (write_data_valid),
    .write_queue_id     (write_queue_id)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_with_fail(input string line);
    $display("%s", line);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  // write port model with ready gaps, late tagged acks and stray ids
  always @(posedge clk) begin
    cyc++;
    avail_at_edge = available_write;
    if (cyc >= max_cycles) begin
      stop_with_fail("timeout: the updates did not finish within 4000 clock cycles");
    end else begin
      #1;
      rng_port = xorshift32(rng_port);
      if (low_left > 0) begin
        low_left--;
        available_write = 1'b0;
      end else begin
        available_write = 1'b1;
        if (rng_port[3:0] == 4'd0) begin
          low_left = int'(rng_port[6:4]) + 1; // short low stretch
        end
      end
      write_data_valid = 1'b0;
      write_queue_id   = '0;
      if (ack_due.size() > 0 && ack_due[0] <= cyc) begin
        void'(ack_due.pop_front());
        write_data_valid = 1'b1;
        write_queue_id   = tag;
        acks_sent++;
      end else if (acks_on && withheld > 0) begin
        withheld--; // release held back acks one per cycle
        write_data_valid = 1'b1;
        write_queue_id   = tag;
        acks_sent++;
      end else if (rng_port[9:8] == 2'd0) begin
        write_data_valid = 1'b1;
        write_queue_id   = (rng_port[31:16] == tag) ? ~tag : rng_port[31:16];
      end
    end
  end

  // writes checked mid cycle
  always @(negedge clk) begin
    if (!dsm_rst_internal && request_write) begin
      assert (avail_at_edge)
        else stop_with_fail($sformatf("MISMATCH at %0t: write after a low ready sample", $time));
      assert (expect_writes && write_idx < total_lines)
        else stop_with_fail($sformatf("MISMATCH at %0t: unexpected write, address %h",
                                      $time, write_data[tag_width +: addr_width]));
      assert (write_data[tag_width-1:0] == tag)
        else stop_with_fail($sformatf("MISMATCH at %0t: tag %h, expected %h",
                                      $time, write_data[tag_width-1:0], tag));
      assert (write_data[tag_width +: addr_width] == base + addr_width'(write_idx))
        else stop_with_fail($sformatf("MISMATCH at %0t: address %h, expected %h", $time,
                                      write_data[tag_width +: addr_width],
                                      base + addr_width'(write_idx)));
      assert (write_data[tag_width + addr_width +: line_width] == exp_line[write_idx])
        else stop_with_fail($sformatf("MISMATCH at %0t: content of line %0d", $time, write_idx));
      write_idx++;
      if (acks_on) begin
        ack_due.push_back(cyc + 4);
      end else begin
        withheld++;
      end
    end
  end

  task automatic drive_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic run_traffic(input int n);
    logic [31:0] r;
    for (int c = 0; c < n; c++) begin
      drive_cycle();
      rng_stim = xorshift32(rng_stim);
      r = rng_stim;
      acc_req_rd_data_en = r[n_rd-1:0];
      acc_req_wr_data_en = r[n_rd +: n_wr];
      for (int i = 0; i < n_rd; i++) begin
        cnt_rd[i] += 32'(r[i]);
      end
      for (int i = 0; i < n_wr; i++) begin
        cnt_wr[i] += 32'(r[n_rd + i]);
      end
    end
    drive_cycle();
    acc_req_rd_data_en = '0; // quiet until the update is done
    acc_req_wr_data_en = '0;
  endtask

  task automatic send_conf(input conf_type_e kind, input logic [31:0] id);
    drive_cycle();
    conf_valid = kind;
    conf       = {base, 32'd64, id};
    drive_cycle();
    conf_valid = conf_none;
  endtask

  task automatic expect_update();
    for (int k = 0; k < total_lines; k++) begin
      exp_line[k] = '0;
    end
    for (int i = 0; i < n_rd; i++) begin
      exp_line[i / counts_per_line][(i % counts_per_line) * 32 +: 32] = cnt_rd[i];
    end
    for (int i = 0; i < n_wr; i++) begin
      exp_line[rd_lines + i / counts_per_line][(i % counts_per_line) * 32 +: 32] = cnt_wr[i];
    end
    for (int k = rd_lines + wr_lines; k < total_lines; k++) begin
      exp_line[k][n_rd-1:0]    = done_rd;
      exp_line[k][n_rd +: n_wr] = done_wr;
      exp_line[k][line_width-1] = done_acc;
    end
    write_idx     = 0;
    expect_writes = 1'b1;
    acks_target  += total_lines;
  endtask

  task automatic finish_update();
    wait (write_idx == total_lines && acks_sent == acks_target);
    repeat (4) drive_cycle(); // writer back in idle
    expect_writes = 1'b0;
  endtask

  initial begin
    for (int i = 0; i < n_rd; i++) begin
      cnt_rd[i] = '0;
    end
    for (int i = 0; i < n_wr; i++) begin
      cnt_wr[i] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    dsm_rst_internal = 1'b0;
    assert (request_write == 1'b0)
      else stop_with_fail($sformatf("MISMATCH at %0t: write request high after reset", $time));

    run_traffic(30);
    drive_cycle();
    done_rd[3] = 1'b1;
    send_conf(conf_in_queue, acc_id);  // wrong type
    send_conf(conf_out_dsm, acc_id + 1); // wrong id
    repeat (40) drive_cycle();
    expect_update();
    send_conf(conf_out_dsm, acc_id);
    finish_update();

    run_traffic(50);
    drive_cycle();
    done_wr[1] = 1'b1;
    expect_update();
    finish_update();
    done_rd[3] = 1'b0; // already reported flag toggled
    repeat (3) drive_cycle();
    done_rd[3] = 1'b1;
    repeat (40) drive_cycle();

    run_traffic(20);
    acks_on = 1'b0;
    drive_cycle();
    done_acc = 1'b1;
    expect_update();
    wait (write_idx == total_lines);
    repeat (30) drive_cycle();
    done_rd[7] = 1'b1; // must wait for the held acks
    repeat (40) drive_cycle();
    expect_update();
    acks_on = 1'b1;
    finish_update();

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire
